// ==== common/cache_pkg.sv ====
// shared word and address types, word size and controller state type
`default_nettype none

package cache_pkg;

    parameter int WORD_SIZE = 32; // bits per data word

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [31:0]          addr_t; // byte address

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,  // victim block out to memory
        FETCH,      // block fill from memory
        PASS,       // uncached access
        FLUSH_SCAN, // look at one frame
        FLUSH_WB,   // write back a dirty frame
        CLEAR
    } cache_state_t;

endpackage

`default_nettype wire

// ==== l1_cache/cache_data_array.sv ====
// block data storage, one word write port and combinational word read
`default_nettype none

module cache_data_array #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 1,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::WORD_SIZE / 8) / ASSOC,
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int SEL_BITS   = SET_BITS + 1 + BLOCK_BITS
) (
    input  wire logic                CLK,
    input  wire logic [SEL_BITS-1:0] word_sel,   // {set, way, word}
    input  wire logic                data_we,
    input  wire cache_pkg::word_t    data_wdata,
    output cache_pkg::word_t         data_rdata
);

    cache_pkg::word_t mem [N_SETS][ASSOC][BLOCK_SIZE];

    logic [SET_BITS-1:0]   sel_set;
    logic                  sel_way;
    logic [BLOCK_BITS-1:0] sel_word;

    assign sel_word = word_sel[BLOCK_BITS-1:0];
    assign sel_way  = word_sel[BLOCK_BITS];
    assign sel_set  = word_sel[SEL_BITS-1 -: SET_BITS];

    // write lands at the next edge
    always_ff @(posedge CLK) begin
        if (data_we) begin
            mem[sel_set][sel_way][sel_word] <= data_wdata;
        end
    end

    assign data_rdata = mem[sel_set][sel_way][sel_word]; // async read

endmodule

`default_nettype wire

// ==== l1_cache/cache_tag_array.sv ====
// valid, dirty and tag storage with hit compare and recently-used bit per set
`default_nettype none

module cache_tag_array #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    parameter int ASSOC      = 1,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::WORD_SIZE / 8) / ASSOC,
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2
) (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire cache_pkg::addr_t    addr,
    input  wire logic [SET_BITS-1:0] scan_set,
    input  wire logic                scan_way,
    input  wire logic                fill_we,   // frame valid, clean, new tag
    input  wire logic                set_dirty,
    input  wire logic                clean_we,
    input  wire logic                inval_all,
    input  wire logic                touch,
    output logic                     hit,
    output logic                     hit_way,
    output logic                     victim_way,
    output logic                     victim_dirty,
    output logic [TAG_BITS-1:0]      victim_tag,
    output logic                     scan_valid,
    output logic                     scan_dirty,
    output logic [TAG_BITS-1:0]      scan_tag
);

    logic                valid_q [N_SETS][ASSOC];
    logic                dirty_q [N_SETS][ASSOC];
    logic [TAG_BITS-1:0] tag_q   [N_SETS][ASSOC];
    logic                used_q  [N_SETS]; // way used last

    logic [SET_BITS-1:0] set;
    logic [TAG_BITS-1:0] tag;

    assign set = addr[BLOCK_BITS+2 +: SET_BITS];
    assign tag = addr[31 -: TAG_BITS];

    // parallel compare of all ways
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < ASSOC; w++) begin
            if (valid_q[set][w] && tag_q[set][w] == tag) begin
                hit     = 1'b1;
                hit_way = 1'(w);
            end
        end
    end

    assign victim_way   = (ASSOC == 1) ? 1'b0 : ~used_q[set];
    assign victim_dirty = valid_q[set][victim_way] & dirty_q[set][victim_way];
    assign victim_tag   = tag_q[set][victim_way];

    assign scan_valid = valid_q[scan_set][scan_way];
    assign scan_dirty = dirty_q[scan_set][scan_way];
    assign scan_tag   = tag_q[scan_set][scan_way];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                used_q[s] <= 1'b0;
                for (int w = 0; w < ASSOC; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end else begin
            if (inval_all) begin
                for (int s = 0; s < N_SETS; s++) begin
                    for (int w = 0; w < ASSOC; w++) begin
                        valid_q[s][w] <= 1'b0;
                        dirty_q[s][w] <= 1'b0;
                    end
                end
            end else begin
                if (fill_we) begin
                    valid_q[set][victim_way] <= 1'b1;
                    dirty_q[set][victim_way] <= 1'b0;
                end
                if (set_dirty) begin
                    dirty_q[set][hit_way] <= 1'b1;
                end
                if (clean_we) begin
                    dirty_q[scan_set][scan_way] <= 1'b0;
                end
            end
            if (touch) begin
                used_q[set] <= hit_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_q[set][victim_way] <= tag;
        end
    end

    // a fill and a full invalidate come from different controller states
    a_fill_inval: assert property (@(posedge CLK) disable iff (!nRST)
        !(fill_we && inval_all));

endmodule

`default_nettype wire

// ==== l1_cache/cache_controller.sv ====
// cache controller FSM for hits, miss write-back and fill, pass-through, flush and clear
`default_nettype none

module cache_controller #(
    parameter int                CACHE_SIZE          = 1024,
    parameter int                BLOCK_SIZE          = 2,
    parameter int                ASSOC               = 1,
    parameter cache_pkg::addr_t  NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::WORD_SIZE / 8) / ASSOC,
    localparam int SET_BITS   = $clog2(N_SETS),
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2,
    localparam int SEL_BITS   = SET_BITS + 1 + BLOCK_BITS
) (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              flush,
    input  wire logic              clear,
    output logic                   flush_done,
    output logic                   clear_done,
    input  wire logic              proc_ren,
    input  wire logic              proc_wen,
    input  wire cache_pkg::addr_t  proc_addr,
    input  wire cache_pkg::word_t  proc_wdata,
    output cache_pkg::word_t       proc_rdata,
    output logic                   proc_busy,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output cache_pkg::addr_t       mem_addr,
    output cache_pkg::word_t       mem_wdata,
    input  wire cache_pkg::word_t  mem_rdata,
    input  wire logic              mem_busy,
    output logic [SET_BITS-1:0]    scan_set,
    output logic                   scan_way,
    output logic                   fill_we,
    output logic                   set_dirty,
    output logic                   clean_we,
    output logic                   inval_all,
    output logic                   touch,
    input  wire logic              hit,
    input  wire logic              hit_way,
    input  wire logic              victim_way,
    input  wire logic              victim_dirty,
    input  wire logic [TAG_BITS-1:0] victim_tag,
    input  wire logic              scan_valid,
    input  wire logic              scan_dirty,
    input  wire logic [TAG_BITS-1:0] scan_tag,
    output logic [SEL_BITS-1:0]    word_sel,
    output logic                   data_we,
    output cache_pkg::word_t       data_wdata,
    input  wire cache_pkg::word_t  data_rdata
);

    cache_pkg::cache_state_t state, state_n;

    logic [BLOCK_BITS-1:0] word_cnt, word_cnt_n;
    logic [SET_BITS-1:0]   set_cnt, set_cnt_n;
    logic                  way_cnt, way_cnt_n;
    logic                  flush_fin; // last frame scanned, clean

    // request address fields
    logic [TAG_BITS-1:0]   req_tag;
    logic [SET_BITS-1:0]   req_set;
    logic [BLOCK_BITS-1:0] req_word;
    logic                  req, uncached, last_word, last_frame;

    assign req_tag  = proc_addr[31 -: TAG_BITS];
    assign req_set  = proc_addr[BLOCK_BITS+2 +: SET_BITS];
    assign req_word = proc_addr[2 +: BLOCK_BITS];
    assign req      = proc_ren | proc_wen;
    assign uncached = proc_addr >= NONCACHE_START_ADDR;

    assign last_word  = word_cnt == BLOCK_BITS'(BLOCK_SIZE - 1);
    assign last_frame = (set_cnt == SET_BITS'(N_SETS - 1)) && (way_cnt == 1'(ASSOC - 1));

    assign scan_set = set_cnt;
    assign scan_way = way_cnt;

    always_comb begin
        state_n    = state;
        word_cnt_n = word_cnt;
        set_cnt_n  = set_cnt;
        way_cnt_n  = way_cnt;
        proc_busy  = 1'b1;
        proc_rdata = data_rdata;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = {req_tag, req_set, word_cnt, 2'b00}; // fill address
        mem_wdata  = data_rdata;
        word_sel   = {req_set, victim_way, word_cnt};
        data_we    = 1'b0;
        data_wdata = mem_rdata;
        fill_we    = 1'b0;
        set_dirty  = 1'b0;
        clean_we   = 1'b0;
        inval_all  = 1'b0;
        touch      = 1'b0;
        flush_fin  = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                word_sel   = {req_set, hit_way, req_word};
                data_wdata = proc_wdata;
                if (flush) begin
                    state_n    = cache_pkg::FLUSH_SCAN;
                    set_cnt_n  = '0;
                    way_cnt_n  = 1'b0;
                    word_cnt_n = '0;
                end else if (clear) begin
                    state_n = cache_pkg::CLEAR;
                end else if (req && uncached) begin
                    state_n = cache_pkg::PASS;
                end else if (req && hit) begin
                    proc_busy = 1'b0; // zero wait hit
                    touch     = 1'b1;
                    data_we   = proc_wen;
                    set_dirty = proc_wen;
                end else if (req) begin
                    state_n = victim_dirty ? cache_pkg::WRITEBACK : cache_pkg::FETCH;
                end
            end
            cache_pkg::PASS: begin
                mem_ren    = proc_ren;
                mem_wen    = proc_wen;
                mem_addr   = proc_addr;
                mem_wdata  = proc_wdata;
                proc_busy  = mem_busy;
                proc_rdata = mem_rdata;
                if (!mem_busy) begin
                    state_n = cache_pkg::IDLE;
                end
            end
            cache_pkg::WRITEBACK: begin
                mem_wen  = 1'b1;
                mem_addr = {victim_tag, req_set, word_cnt, 2'b00};
                if (!mem_busy) begin
                    word_cnt_n = word_cnt + 1'b1; // wraps to 0 after last word
                    if (last_word) begin
                        state_n = cache_pkg::FETCH;
                    end
                end
            end
            cache_pkg::FETCH: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    data_we    = 1'b1;
                    word_cnt_n = word_cnt + 1'b1;
                    if (last_word) begin
                        fill_we = 1'b1; // frame valid, request hits next cycle
                        state_n = cache_pkg::IDLE;
                    end
                end
            end
            cache_pkg::FLUSH_SCAN: begin
                if (scan_valid && scan_dirty) begin
                    state_n = cache_pkg::FLUSH_WB;
                end else if (last_frame) begin
                    inval_all = 1'b1;
                    flush_fin = 1'b1;
                    state_n   = cache_pkg::IDLE;
                end else begin
                    // next way, then next set
                    way_cnt_n = (way_cnt == 1'(ASSOC - 1)) ? 1'b0 : 1'b1;
                    if (way_cnt == 1'(ASSOC - 1)) begin
                        set_cnt_n = set_cnt + 1'b1;
                    end
                end
            end
            cache_pkg::FLUSH_WB: begin
                mem_wen  = 1'b1;
                mem_addr = {scan_tag, set_cnt, word_cnt, 2'b00};
                word_sel = {set_cnt, way_cnt, word_cnt};
                if (!mem_busy) begin
                    word_cnt_n = word_cnt + 1'b1;
                    if (last_word) begin
                        clean_we = 1'b1; // rescan sees it clean and moves on
                        state_n  = cache_pkg::FLUSH_SCAN;
                    end
                end
            end
            cache_pkg::CLEAR: begin
                inval_all = 1'b1;
                state_n   = cache_pkg::IDLE;
            end
            default: begin
                state_n = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state      <= cache_pkg::IDLE;
            word_cnt   <= '0;
            set_cnt    <= '0;
            way_cnt    <= 1'b0;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            state      <= state_n;
            word_cnt   <= word_cnt_n;
            set_cnt    <= set_cnt_n;
            way_cnt    <= way_cnt_n;
            flush_done <= flush_fin;                     // one cycle after invalidate
            clear_done <= state == cache_pkg::CLEAR;
        end
    end

    // memory port carries one direction at a time, also in pass-through
    a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen));

    // processor only sees completion for a pending access
    a_busy_low_req: assert property (@(posedge CLK) disable iff (!nRST)
        !proc_busy |-> (proc_ren || proc_wen));

endmodule

`default_nettype wire

// ==== l1_cache/l1_cache.sv ====
// L1 cache top level with controller, tag array and data array
`default_nettype none

module l1_cache #(
    parameter int                CACHE_SIZE          = 1024, // bytes, power of 2
    parameter int                BLOCK_SIZE          = 2,    // words per block, 2 or more
    parameter int                ASSOC               = 1,    // 1 or 2
    parameter cache_pkg::addr_t  NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              flush,
    input  wire logic              clear,
    output logic                   flush_done,
    output logic                   clear_done,
    input  wire logic              proc_ren,
    input  wire logic              proc_wen,
    input  wire cache_pkg::addr_t  proc_addr,
    input  wire cache_pkg::word_t  proc_wdata,
    output cache_pkg::word_t       proc_rdata,
    output logic                   proc_busy,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output cache_pkg::addr_t       mem_addr,
    output cache_pkg::word_t       mem_wdata,
    input  wire cache_pkg::word_t  mem_rdata,
    input  wire logic              mem_busy
);

    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * cache_pkg::WORD_SIZE / 8) / ASSOC;
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2;
    localparam int SEL_BITS   = SET_BITS + 1 + BLOCK_BITS; // set, way, word

    // controller <-> tag array
    logic [SET_BITS-1:0] scan_set;
    logic                scan_way;
    logic                fill_we, set_dirty, clean_we, inval_all, touch;
    logic                hit, hit_way, victim_way, victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    logic                scan_valid, scan_dirty;
    logic [TAG_BITS-1:0] scan_tag;

    // controller <-> data array
    logic [SEL_BITS-1:0] word_sel;
    logic                data_we;
    cache_pkg::word_t    data_wdata;
    cache_pkg::word_t    data_rdata;

    cache_controller #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .ASSOC               (ASSOC),
        .NONCACHE_START_ADDR (NONCACHE_START_ADDR)
    ) u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .clear        (clear),
        .flush_done   (flush_done),
        .clear_done   (clear_done),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .scan_set     (scan_set),
        .scan_way     (scan_way),
        .fill_we      (fill_we),
        .set_dirty    (set_dirty),
        .clean_we     (clean_we),
        .inval_all    (inval_all),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .scan_valid   (scan_valid),
        .scan_dirty   (scan_dirty),
        .scan_tag     (scan_tag),
        .word_sel     (word_sel),
        .data_we      (data_we),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata)
    );

    cache_tag_array #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE),
        .ASSOC      (ASSOC)
    ) u_tags (
        .CLK          (CLK),
        .nRST         (nRST),
        .addr         (proc_addr),
        .scan_set     (scan_set),
        .scan_way     (scan_way),
        .fill_we      (fill_we),
        .set_dirty    (set_dirty),
        .clean_we     (clean_we),
        .inval_all    (inval_all),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .scan_valid   (scan_valid),
        .scan_dirty   (scan_dirty),
        .scan_tag     (scan_tag)
    );

    cache_data_array #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE),
        .ASSOC      (ASSOC)
    ) u_data (
        .CLK        (CLK),
        .word_sel   (word_sel),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// clock and active low reset generator for the testbench
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4, // ns
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1; // release on a rising edge
    end

endmodule

`default_nettype wire

// ==== verification/tb_mem_model.sv ====
// memory slave with random wait states and an inspectable word array
`default_nettype none

module tb_mem_model #(
    parameter int               MAX_WAIT = 3,
    parameter int               SEED     = 46844,
    parameter cache_pkg::word_t FILL_XOR = 32'h5A3C_96E1
) (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              mem_ren,
    input  wire logic              mem_wen,
    input  wire cache_pkg::addr_t  mem_addr,
    input  wire cache_pkg::word_t  mem_wdata,
    output cache_pkg::word_t       mem_rdata,
    output logic                   mem_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // two 64-word windows, picked by address bit 31
    cache_pkg::word_t words [128];

    int         seed = SEED;
    logic       active;   // a word transfer is under way
    int         wait_cnt;
    logic [6:0] idx;

    assign idx       = {mem_addr[31], mem_addr[7:2]};
    assign mem_rdata = words[idx];
    assign mem_busy  = !(active && wait_cnt == 0);

    initial begin
        for (int i = 0; i < 128; i++) begin
            words[i] = {i[6], 23'd0, i[5:0], 2'b00} ^ FILL_XOR; // full address pattern
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            active   <= 1'b0;
            wait_cnt <= 0;
        end else if (!active) begin
            if (mem_ren || mem_wen) begin
                active   <= 1'b1;
                wait_cnt <= $unsigned($random(seed)) % (MAX_WAIT + 1);
            end
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            active <= 1'b0; // word completes on this edge
        end
    end

    always @(posedge CLK) begin
        if (active && wait_cnt == 0 && mem_wen) begin
            words[idx] <= mem_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_l1_cache.sv ====
// testbench top with random mix, hit, pass-through, flush and clear tests, watchdog and report
`default_nettype none

module tb_l1_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int               PERIOD     = 4;
    localparam int               BLOCK_SIZE = 2;
    localparam int               MAX_WAIT   = 3;
    localparam int               N_RANDOM   = 400;
    localparam int               N_HITS     = 16;
    localparam int               N_OPS      = N_RANDOM + 2 * N_HITS + 32; // directed ops too
    localparam int               MARGIN     = 4;
    localparam cache_pkg::addr_t UNCACHED   = 32'h8000_0000;
    localparam cache_pkg::word_t FILL_XOR   = 32'h5A3C_96E1;

    logic             CLK, nRST;
    logic             flush, clear, flush_done, clear_done;
    logic             proc_ren, proc_wen, proc_busy;
    cache_pkg::addr_t proc_addr;
    cache_pkg::word_t proc_wdata, proc_rdata;
    logic             mem_ren, mem_wen, mem_busy;
    cache_pkg::addr_t mem_addr;
    cache_pkg::word_t mem_wdata, mem_rdata;

    cache_pkg::word_t shadow [cache_pkg::addr_t]; // last value written per address
    int               seed         = 46844;
    int               err_count    = 0;
    int               tests_run    = 0;
    int               tests_failed = 0;
    int               ren_cycles   = 0;
    int               wen_cycles   = 0;
    cache_pkg::addr_t last_wr_addr;
    cache_pkg::word_t last_wr_data;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(5)) u_clock (.*);

    tb_mem_model #(.MAX_WAIT(MAX_WAIT), .SEED(46844), .FILL_XOR(FILL_XOR)) u_mem (.*);

    l1_cache #(
        .CACHE_SIZE          (64),  // 4 sets of 2 ways
        .BLOCK_SIZE          (BLOCK_SIZE),
        .ASSOC               (2),
        .NONCACHE_START_ADDR (UNCACHED)
    ) DUT (.*);

    // memory port activity sampled away from the clock edge
    always @(negedge CLK) begin
        if (mem_ren) begin
            ren_cycles++;
        end
        if (mem_wen) begin
            wen_cycles++;
        end
        if (mem_wen && !mem_busy) begin
            last_wr_addr = mem_addr;
            last_wr_data = mem_wdata;
        end
    end

    function automatic cache_pkg::word_t model_value(cache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_XOR; // never written
    endfunction

    function automatic cache_pkg::addr_t random_addr(logic uncached);
        logic [5:0] word;
        word = 6'($unsigned($random(seed)));
        return {uncached, 23'd0, word, 2'b00};
    endfunction

    function automatic cache_pkg::addr_t index_addr(int i);
        logic [6:0] idx;
        idx = 7'(i);
        return {idx[6], 23'd0, idx[5:0], 2'b00};
    endfunction

    task automatic check_word(input string name, input cache_pkg::word_t exp,
                              input cache_pkg::word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_addr(input string name, input cache_pkg::addr_t exp,
                                input cache_pkg::addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (err_count == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - start);
        end
    endtask

    // one processor access held until busy falls
    task automatic access(input logic write, input cache_pkg::addr_t a,
                          input cache_pkg::word_t wd, output cache_pkg::word_t rd);
        @(posedge CLK);
        proc_ren   <= !write;
        proc_wen   <= write;
        proc_addr  <= a;
        proc_wdata <= wd;
        @(negedge CLK);
        while (proc_busy) begin
            @(negedge CLK);
        end
        rd = proc_rdata;
        @(posedge CLK);
        proc_ren <= 1'b0;
        proc_wen <= 1'b0;
    endtask

    initial begin
        cache_pkg::addr_t a, hit_addr;
        cache_pkg::word_t wd, rd;
        int               start, ren_before, wen_before;
        cache_pkg::addr_t dirty_addr [4];
        cache_pkg::word_t old_word [4];

        flush      = 1'b0;
        clear      = 1'b0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        hit_addr   = '0;
        @(posedge nRST);

        start = err_count;
        for (int n = 0; n < N_RANDOM; n++) begin
            a = random_addr(($random(seed) & 7) == 0); // mostly cacheable
            if ($random(seed) & 1) begin
                wd = $random(seed);
                access(1'b1, a, wd, rd);
                shadow[a] = wd;
            end else begin
                access(1'b0, a, '0, rd);
                check_word($sformatf("random mix read %h", a), model_value(a), rd);
            end
        end
        report_test("random mix", start);

        start = err_count;
        for (int k = 0; k < N_HITS; k++) begin
            hit_addr = random_addr(1'b0);
            access(1'b0, hit_addr, '0, rd);
            check_word($sformatf("hit without traffic first read %h", hit_addr),
                       model_value(hit_addr), rd);
            ren_before = ren_cycles;
            wen_before = wen_cycles;
            access(1'b0, hit_addr, '0, rd);
            check_word($sformatf("hit without traffic repeat read %h", hit_addr),
                       model_value(hit_addr), rd);
            if (ren_cycles != ren_before || wen_cycles != wen_before) begin
                $display("Error: repeated read at %h went to memory", hit_addr);
                err_count++;
            end
        end
        report_test("hit without traffic", start);

        start = err_count;
        for (int k = 0; k < 4; k++) begin
            a  = random_addr(1'b1);
            wd = $random(seed);
            wen_before = wen_cycles;
            access(1'b1, a, wd, rd);
            shadow[a] = wd;
            @(negedge CLK);
            if (wen_cycles == wen_before) begin
                $display("Error: uncached write at %h never reached memory", a);
                err_count++;
            end
            compare_addr("pass-through address", a, last_wr_addr);
            check_word("pass-through data", wd, last_wr_data);
            check_word("memory after pass-through", wd, u_mem.words[{a[31], a[7:2]}]);
        end
        report_test("pass-through", start);

        start = err_count;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(negedge CLK);
        check_flag("flush_done one cycle", 1'b0, flush_done);
        for (int i = 0; i < 128; i++) begin
            a = index_addr(i);
            check_word($sformatf("memory %h after flush", a), model_value(a), u_mem.words[i]);
        end
        ren_before = ren_cycles;
        access(1'b0, hit_addr, '0, rd);
        check_word("read after flush", model_value(hit_addr), rd);
        if (ren_cycles == ren_before) begin
            $display("Error: read at %h after flush did not fetch from memory", hit_addr);
            err_count++;
        end
        report_test("flush", start);

        start = err_count;
        for (int k = 0; k < 4; k++) begin
            dirty_addr[k] = cache_pkg::addr_t'(k * 8); // one block in each set
            old_word[k]   = model_value(dirty_addr[k]);
            access(1'b1, dirty_addr[k], ~old_word[k], rd);
        end
        @(posedge CLK);
        clear <= 1'b1;
        @(posedge CLK);
        clear <= 1'b0;
        @(negedge CLK);
        check_flag("clear_done while invalidating", 1'b0, clear_done);
        @(negedge CLK);
        check_flag("clear_done pulse", 1'b1, clear_done);
        @(negedge CLK);
        check_flag("clear_done after pulse", 1'b0, clear_done);
        for (int k = 0; k < 4; k++) begin
            access(1'b0, dirty_addr[k], '0, rd);
            check_word($sformatf("read %h after clear", dirty_addr[k]), old_word[k], rd);
        end
        report_test("clear", start);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // worst case is a dirty miss per operation
    initial begin
        cache_pkg::cache_state_t stuck;
        #(N_OPS * BLOCK_SIZE * (MAX_WAIT + 2) * MARGIN * PERIOD);
        stuck = DUT.u_ctrl.state;
        $display("Error: run timed out at %0d ns with the controller in state %s",
                 $time, stuck.name());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/cache_pkg.sv
l1_cache/cache_data_array.sv
l1_cache/cache_tag_array.sv
l1_cache/cache_controller.sv
l1_cache/l1_cache.sv
verification/tb_clock.sv
verification/tb_mem_model.sv
verification/tb_l1_cache.sv

// ==== Makefile ====
TOP = tb_l1_cache

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: sim clean
